//--- include/k16_consts.svh
`ifndef K16_CONSTS_SVH
`define K16_CONSTS_SVH

// Data and address width
`define K16_WORD_BITS 16

// General registers, the last one is the PC
`define K16_NUM_REGS 8

`define K16_PC_REG 7

// RAM decodes only the low address bits
`define K16_RAM_WORDS 4096

// JMP encoding with every offset bit set
`define K16_HALT_WORD 16'h9FFF

`endif

//--- src/k16_isa_pkg.sv
`include "k16_consts.svh"

package k16_isa_pkg;

  typedef logic [`K16_WORD_BITS-1:0] word_t;

  typedef logic [$clog2(`K16_NUM_REGS)-1:0] reg_idx_t;

  typedef enum logic [1:0] {
    ALU_ARITH = 2'd0,
    ALU_LOGIC = 2'd1,
    ALU_IMM   = 2'd2
  } alu_class_t;

  typedef logic [2:0] alu_op_t;

  // Arithmetic and logic ops match instruction bits 2..0
  localparam alu_op_t OP_ADD = 3'd0;
  localparam alu_op_t OP_ADC = 3'd1;
  localparam alu_op_t OP_SUB = 3'd2;
  localparam alu_op_t OP_SBC = 3'd3;
  localparam alu_op_t OP_AND = 3'd4;
  localparam alu_op_t OP_OR  = 3'd5;
  localparam alu_op_t OP_XOR = 3'd6;
  localparam alu_op_t OP_NOT = 3'd7;

  // Immediate loads, taken from instruction bits 9..8
  localparam alu_op_t IMM_LDL  = 3'd0;
  localparam alu_op_t IMM_LDH  = 3'd1;
  localparam alu_op_t IMM_LDLZ = 3'd2;
  localparam alu_op_t IMM_LDHZ = 3'd3;

  typedef struct packed {
    logic carry;
    logic zero;
    logic negative;
  } flags_t;

endpackage

//--- src/k16_bus_pkg.sv
package k16_bus_pkg;

  // One RAM access from either master
  typedef struct packed {
    logic               req;
    logic               write;
    k16_isa_pkg::word_t addr;
    k16_isa_pkg::word_t wdata;
  } mem_req_t;

  typedef enum logic [1:0] {
    PANEL_DEPOSIT = 2'd0,
    PANEL_EXAMINE = 2'd1,
    PANEL_START   = 2'd2
  } panel_op_t;

  // Start uses addr as the start PC
  typedef struct packed {
    panel_op_t          op;
    k16_isa_pkg::word_t addr;
    k16_isa_pkg::word_t data;
  } panel_cmd_t;

endpackage

//--- src/k16_alu.sv
`timescale 1ns/1ps
`include "k16_consts.svh"

module k16_alu (
  input  k16_isa_pkg::alu_class_t op_class,
  input  k16_isa_pkg::alu_op_t    op,
  input  k16_isa_pkg::word_t      a,
  input  k16_isa_pkg::word_t      b,
  input  logic                    carry_in,
  output k16_isa_pkg::word_t      result,
  output k16_isa_pkg::flags_t     flags_out
);

  logic [`K16_WORD_BITS:0] wide;
  logic                    carry;

  always_comb
  begin
    wide = {1'b0, a};
    result = a;
    carry = carry_in;
    case (op_class)
      k16_isa_pkg::ALU_ARITH:
      begin
        // Top bit is carry on add, borrow on subtract
        case (op)
          k16_isa_pkg::OP_ADD: wide = {1'b0, a} + {1'b0, b};
          k16_isa_pkg::OP_ADC: wide = {1'b0, a} + {1'b0, b} + carry_in;
          k16_isa_pkg::OP_SUB: wide = {1'b0, a} - {1'b0, b};
          k16_isa_pkg::OP_SBC: wide = {1'b0, a} - {1'b0, b} - carry_in;
          default: wide = {1'b0, a};
        endcase
        result = wide[`K16_WORD_BITS-1:0];
        carry = wide[`K16_WORD_BITS];
      end
      k16_isa_pkg::ALU_LOGIC:
      begin
        case (op)
          k16_isa_pkg::OP_AND: result = a & b;
          k16_isa_pkg::OP_OR:  result = a | b;
          k16_isa_pkg::OP_XOR: result = a ^ b;
          k16_isa_pkg::OP_NOT: result = ~a;
          default: result = a;
        endcase
      end
      k16_isa_pkg::ALU_IMM:
      begin
        // Immediate byte sits in b[7:0]
        case (op)
          k16_isa_pkg::IMM_LDL:  result = {a[15:8], b[7:0]};
          k16_isa_pkg::IMM_LDH:  result = {b[7:0], a[7:0]};
          k16_isa_pkg::IMM_LDLZ: result = {8'h00, b[7:0]};
          k16_isa_pkg::IMM_LDHZ: result = {b[7:0], 8'h00};
          default: result = a;
        endcase
      end
      default:
        result = a;
    endcase
  end

  assign flags_out.carry = carry;
  assign flags_out.zero = (result == '0);
  assign flags_out.negative = result[`K16_WORD_BITS-1];

endmodule

//--- src/k16_core.sv
`timescale 1ns/1ps
`include "k16_consts.svh"

module k16_core (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  k16_isa_pkg::word_t    start_pc,
  input  k16_isa_pkg::word_t    rdata,
  output k16_bus_pkg::mem_req_t core_req,
  output logic                  halted
);

  typedef enum logic [3:0] {
    S_HALT, S_FETCH, S_WAIT, S_DECODE, S_EXEC,
    S_JUMP, S_MEM_ADDR, S_LD_REQ, S_LD_DATA, S_ST_REQ
  } state_t;

  state_t                  state;
  k16_isa_pkg::word_t      regs [`K16_NUM_REGS];
  k16_isa_pkg::word_t      ir;
  k16_isa_pkg::flags_t     flags;

  // Latched at decode
  k16_isa_pkg::alu_class_t alu_class;
  k16_isa_pkg::alu_op_t    alu_op;
  k16_isa_pkg::word_t      op_a;
  k16_isa_pkg::word_t      op_b;
  k16_isa_pkg::reg_idx_t   dest;
  logic                    wr_reg;
  logic                    wr_carry;
  logic                    is_store;
  k16_isa_pkg::word_t      mem_addr;

  k16_isa_pkg::word_t      alu_result;
  k16_isa_pkg::flags_t     alu_flags;

  k16_isa_pkg::reg_idx_t   f_dst;
  k16_isa_pkg::reg_idx_t   f_sa;
  k16_isa_pkg::reg_idx_t   f_sb;
  k16_isa_pkg::word_t      off7;
  k16_isa_pkg::word_t      off10;
  logic                    branch_taken;

  assign f_dst = ir[12:10];
  assign f_sa = ir[9:7];
  assign f_sb = ir[6:4];
  assign off7 = {{(`K16_WORD_BITS-7){ir[6]}}, ir[6:0]};
  assign off10 = {{(`K16_WORD_BITS-10){ir[9]}}, ir[9:0]};

  // BOS and BOC have no overflow flag behind them
  always_comb
  begin
    case (f_dst)
      3'd0: branch_taken = flags.carry;
      3'd1: branch_taken = ~flags.carry;
      3'd2: branch_taken = flags.zero;
      3'd3: branch_taken = ~flags.zero;
      3'd4: branch_taken = flags.negative;
      3'd5: branch_taken = ~flags.negative;
      default: branch_taken = 1'b0;
    endcase
  end

  k16_alu u_alu (
    .op_class  (alu_class),
    .op        (alu_op),
    .a         (op_a),
    .b         (op_b),
    .carry_in  (flags.carry),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= S_HALT;
      flags <= '0;
    end
    else
    begin
      case (state)
        S_HALT:
        begin
          if (start)
          begin
            regs[`K16_PC_REG] <= start_pc;
            state <= S_FETCH;
          end
        end
        S_FETCH:
          state <= S_WAIT;
        S_WAIT:
        begin
          ir <= rdata;
          regs[`K16_PC_REG] <= regs[`K16_PC_REG] + 1'b1;
          state <= S_DECODE;
        end
        S_DECODE:
        begin
          alu_class <= k16_isa_pkg::ALU_ARITH;
          alu_op <= k16_isa_pkg::OP_ADD;
          op_a <= regs[f_sa];
          op_b <= regs[f_sb];
          dest <= f_dst;
          wr_reg <= 1'b1;
          wr_carry <= 1'b0;
          is_store <= 1'b0;
          casez (ir)
            16'b000?_????_????_00??:
            begin
              alu_op <= ir[2:0];
              wr_carry <= 1'b1;
              state <= S_EXEC;
            end
            16'b000?_????_????_01??:
            begin
              alu_class <= k16_isa_pkg::ALU_LOGIC;
              alu_op <= ir[2:0];
              state <= S_EXEC;
            end
            16'b000?_????_????_1100:
            begin
              op_b <= k16_isa_pkg::word_t'(1);
              state <= S_EXEC;
            end
            16'b000?_????_????_1110:
            begin
              // CMP
              alu_op <= k16_isa_pkg::OP_SUB;
              wr_reg <= 1'b0;
              wr_carry <= 1'b1;
              state <= S_EXEC;
            end
            16'b000?_????_????_1111:
            begin
              alu_op <= k16_isa_pkg::OP_SUB;
              op_b <= k16_isa_pkg::word_t'(1);
              state <= S_EXEC;
            end
            16'b010?_????_????_????:
            begin
              op_b <= off7;
              state <= branch_taken ? S_JUMP : S_FETCH;
            end
            16'b011?_????_????_????:
            begin
              alu_class <= k16_isa_pkg::ALU_IMM;
              alu_op <= {1'b0, ir[9:8]};
              op_a <= regs[f_dst];
              op_b <= {8'h00, ir[7:0]};
              state <= S_EXEC;
            end
            16'b100?_????_????_????:
            begin
              op_a <= regs[f_dst];
              op_b <= off10;
              state <= (ir == `K16_HALT_WORD) ? S_HALT : S_JUMP;
            end
            16'b110?_????_????_????:
            begin
              op_b <= off7;
              state <= S_MEM_ADDR;
            end
            16'b111?_????_????_????:
            begin
              op_b <= off7;
              is_store <= 1'b1;
              state <= S_MEM_ADDR;
            end
            default:
              state <= S_HALT;
          endcase
        end
        S_EXEC:
        begin
          if (wr_reg)
            regs[dest] <= alu_result;
          if (wr_carry)
            flags.carry <= alu_flags.carry;
          flags.zero <= alu_flags.zero;
          flags.negative <= alu_flags.negative;
          state <= S_FETCH;
        end
        S_JUMP:
        begin
          regs[`K16_PC_REG] <= alu_result;
          state <= S_FETCH;
        end
        S_MEM_ADDR:
        begin
          mem_addr <= alu_result;
          state <= is_store ? S_ST_REQ : S_LD_REQ;
        end
        S_LD_REQ:
          state <= S_LD_DATA;
        S_LD_DATA:
        begin
          regs[dest] <= rdata;
          flags.zero <= (rdata == '0);
          flags.negative <= rdata[`K16_WORD_BITS-1];
          state <= S_FETCH;
        end
        S_ST_REQ:
          state <= S_FETCH;
        default:
          state <= S_HALT;
      endcase
    end
  end

  always_comb
  begin
    core_req = '0;
    core_req.addr = mem_addr;
    core_req.wdata = regs[dest];
    if (state == S_FETCH)
    begin
      core_req.req = 1'b1;
      core_req.addr = regs[`K16_PC_REG];
    end
    else if (state == S_LD_REQ)
      core_req.req = 1'b1;
    else if (state == S_ST_REQ)
    begin
      core_req.req = 1'b1;
      core_req.write = 1'b1;
    end
  end

  assign halted = (state == S_HALT);

  // Start comes from the panel only while the core sits halted
  assert property (@(posedge clk) disable iff (reset) start |-> halted);

endmodule

//--- src/k16_panel.sv
`timescale 1ns/1ps

module k16_panel (
  input  logic                    clk,
  input  logic                    reset,
  input  k16_bus_pkg::panel_cmd_t panel_cmd,
  input  logic                    panel_valid,
  input  logic                    halted,
  input  logic                    panel_grant,
  input  k16_isa_pkg::word_t      rdata,
  output k16_bus_pkg::mem_req_t   panel_req,
  output logic                    start,
  output k16_isa_pkg::word_t      start_pc,
  output logic                    panel_ready,
  output logic                    panel_done,
  output k16_isa_pkg::word_t      examine_data
);

  typedef enum logic [1:0] {P_IDLE, P_MEM, P_READ, P_START} state_t;

  state_t                  state;
  k16_bus_pkg::panel_cmd_t cmd;
  logic                    is_deposit;

  assign is_deposit = (cmd.op == k16_bus_pkg::PANEL_DEPOSIT);

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= P_IDLE;
    else
    begin
      case (state)
        P_IDLE:
        begin
          if (panel_valid && panel_ready)
          begin
            cmd <= panel_cmd;
            if (panel_cmd.op == k16_bus_pkg::PANEL_START)
              state <= P_START;
            else
              state <= P_MEM;
          end
        end
        // Request held until the arbiter lets it through
        P_MEM:
        begin
          if (panel_grant)
            state <= is_deposit ? P_IDLE : P_READ;
        end
        default:
          state <= P_IDLE;
      endcase
    end
  end

  always_comb
  begin
    panel_req.req = (state == P_MEM);
    panel_req.write = is_deposit;
    panel_req.addr = cmd.addr;
    panel_req.wdata = cmd.data;
  end

  assign panel_ready = (state == P_IDLE) && halted;
  assign panel_done = (state == P_MEM && panel_grant && is_deposit) ||
                      (state == P_READ) || (state == P_START);
  assign examine_data = (state == P_READ) ? rdata : '0;
  assign start = (state == P_START);
  assign start_pc = cmd.addr;

  assert property (@(posedge clk) disable iff (reset) panel_valid |-> panel_ready);

endmodule

//--- src/k16_bus_arbiter.sv
`timescale 1ns/1ps

module k16_bus_arbiter (
  input  k16_bus_pkg::mem_req_t core_req,
  input  k16_bus_pkg::mem_req_t panel_req,
  output k16_bus_pkg::mem_req_t mem_req,
  output logic                  panel_grant
);

  // Core always wins
  assign panel_grant = panel_req.req && !core_req.req;
  assign mem_req = core_req.req ? core_req : panel_req;

  // Panel only runs against a halted core, so the masters never meet here
  always_comb
  begin
    assert (!(core_req.req && panel_req.req));
  end

endmodule

//--- src/k16_ram.sv
`timescale 1ns/1ps
`include "k16_consts.svh"

module k16_ram (
  input  logic                  clk,
  input  k16_bus_pkg::mem_req_t mem_req,
  output k16_isa_pkg::word_t    rdata
);

  localparam int ADDR_BITS = $clog2(`K16_RAM_WORDS);

  k16_isa_pkg::word_t mem [`K16_RAM_WORDS];

  // Read data holds until the next read
  always_ff @(posedge clk)
  begin
    if (mem_req.req && mem_req.write)
      mem[mem_req.addr[ADDR_BITS-1:0]] <= mem_req.wdata;
    else if (mem_req.req)
      rdata <= mem[mem_req.addr[ADDR_BITS-1:0]];
  end

endmodule

//--- src/k16_system.sv
`timescale 1ns/1ps

module k16_system (
  input  logic                    clk,
  input  logic                    reset,
  input  k16_bus_pkg::panel_cmd_t panel_cmd,
  input  logic                    panel_valid,
  output logic                    panel_ready,
  output logic                    panel_done,
  output k16_isa_pkg::word_t      examine_data,
  output logic                    halted
);

  k16_bus_pkg::mem_req_t core_req;
  k16_bus_pkg::mem_req_t panel_req;
  k16_bus_pkg::mem_req_t mem_req;
  logic                  panel_grant;
  logic                  start;
  k16_isa_pkg::word_t    start_pc;
  k16_isa_pkg::word_t    rdata;

  k16_core u_core (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .start_pc (start_pc),
    .rdata    (rdata),
    .core_req (core_req),
    .halted   (halted)
  );

  k16_panel u_panel (
    .clk          (clk),
    .reset        (reset),
    .panel_cmd    (panel_cmd),
    .panel_valid  (panel_valid),
    .halted       (halted),
    .panel_grant  (panel_grant),
    .rdata        (rdata),
    .panel_req    (panel_req),
    .start        (start),
    .start_pc     (start_pc),
    .panel_ready  (panel_ready),
    .panel_done   (panel_done),
    .examine_data (examine_data)
  );

  k16_bus_arbiter u_arbiter (
    .core_req    (core_req),
    .panel_req   (panel_req),
    .mem_req     (mem_req),
    .panel_grant (panel_grant)
  );

  k16_ram u_ram (
    .clk     (clk),
    .mem_req (mem_req),
    .rdata   (rdata)
  );

endmodule

//--- test/k16_system_tb.sv
`timescale 1ns/1ps
`include "k16_consts.svh"

module k16_system_tb;

  localparam int PANEL_TIMEOUT = 50;
  localparam int RUN_TIMEOUT = 2000;

  // Data words sit above the short test programs
  localparam k16_isa_pkg::word_t DATA_A = 16'h0030;
  localparam k16_isa_pkg::word_t DATA_B = 16'h0031;
  localparam k16_isa_pkg::word_t DATA_OUT = 16'h0032;
  localparam k16_isa_pkg::word_t MARKER = 16'h00A5;

  typedef struct packed {
    k16_isa_pkg::word_t  result;
    k16_isa_pkg::flags_t flags;
  } alu_out_t;

  logic                    clk;
  logic                    reset;
  k16_bus_pkg::panel_cmd_t panel_cmd;
  logic                    panel_valid;
  logic                    panel_ready;
  logic                    panel_done;
  k16_isa_pkg::word_t      examine_data;
  logic                    halted;

  int                      error_count;
  int                      check_count;
  int                      test_count;
  int                      errors_at_start;
  int                      checks_at_start;
  k16_isa_pkg::word_t      program_q [$];

  k16_system u_dut (
    .clk          (clk),
    .reset        (reset),
    .panel_cmd    (panel_cmd),
    .panel_valid  (panel_valid),
    .panel_ready  (panel_ready),
    .panel_done   (panel_done),
    .examine_data (examine_data),
    .halted       (halted)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #20 clk = ~clk;
  end

  // Expected ALU behaviour built from the instruction set rules
  function automatic alu_out_t k16_ref_alu(
    input k16_isa_pkg::alu_class_t op_class,
    input k16_isa_pkg::alu_op_t    op,
    input k16_isa_pkg::word_t      a,
    input k16_isa_pkg::word_t      b,
    input logic                    carry
  );
    alu_out_t out;
    int       full;
    out.result = a;
    out.flags.carry = carry;
    full = 0;
    case (op_class)
      k16_isa_pkg::ALU_ARITH:
      begin
        case (op)
          k16_isa_pkg::OP_ADD: full = int'(a) + int'(b);
          k16_isa_pkg::OP_ADC: full = int'(a) + int'(b) + int'(carry);
          k16_isa_pkg::OP_SUB: full = int'(a) - int'(b);
          default: full = int'(a) - int'(b) - int'(carry);
        endcase
        out.result = full[15:0];
        // Carry past the word or borrow below zero
        out.flags.carry = (full > 65535) || (full < 0);
      end
      k16_isa_pkg::ALU_LOGIC:
      begin
        case (op)
          k16_isa_pkg::OP_AND: out.result = a & b;
          k16_isa_pkg::OP_OR:  out.result = a | b;
          k16_isa_pkg::OP_XOR: out.result = a ^ b;
          default: out.result = ~a;
        endcase
      end
      default:
      begin
        case (op)
          k16_isa_pkg::IMM_LDL:  out.result = {a[15:8], b[7:0]};
          k16_isa_pkg::IMM_LDH:  out.result = {b[7:0], a[7:0]};
          k16_isa_pkg::IMM_LDLZ: out.result = {8'h00, b[7:0]};
          default: out.result = {b[7:0], 8'h00};
        endcase
      end
    endcase
    out.flags.zero = (out.result == 16'h0000);
    out.flags.negative = out.result[15];
    return out;
  endfunction

  // Conditions in order BCS BCC BZS BZC BNS BNC BOS BOC
  function automatic logic branch_expected(input logic [2:0] cond,
                                           input k16_isa_pkg::flags_t f);
    case (cond)
      3'd0: return f.carry;
      3'd1: return !f.carry;
      3'd2: return f.zero;
      3'd3: return !f.zero;
      3'd4: return f.negative;
      3'd5: return !f.negative;
      default: return 1'b0;
    endcase
  endfunction

  function automatic k16_isa_pkg::word_t reg_op(input k16_isa_pkg::reg_idx_t d,
    input k16_isa_pkg::reg_idx_t sa, input k16_isa_pkg::reg_idx_t sb, input logic [3:0] code);
    return {3'b000, d, sa, sb, code};
  endfunction

  function automatic k16_isa_pkg::word_t load_imm(input k16_isa_pkg::reg_idx_t d,
    input k16_isa_pkg::alu_op_t op, input logic [7:0] imm);
    return {3'b011, d, op[1:0], imm};
  endfunction

  function automatic k16_isa_pkg::word_t load_word(input k16_isa_pkg::reg_idx_t d,
    input k16_isa_pkg::reg_idx_t sa, input logic [6:0] off);
    return {3'b110, d, sa, off};
  endfunction

  function automatic k16_isa_pkg::word_t store_word(input k16_isa_pkg::reg_idx_t src,
    input k16_isa_pkg::reg_idx_t sa, input logic [6:0] off);
    return {3'b111, src, sa, off};
  endfunction

  // Offset counts from the next instruction
  function automatic k16_isa_pkg::word_t branch_if(input logic [2:0] cond,
                                                   input logic [6:0] off);
    return {3'b010, cond, 3'd7, off};
  endfunction

  function automatic k16_isa_pkg::word_t jump_rel(input logic [9:0] off);
    return {3'b100, 3'd7, off};
  endfunction

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic panel_command(
    input  k16_bus_pkg::panel_op_t op,
    input  k16_isa_pkg::word_t     addr,
    input  k16_isa_pkg::word_t     data,
    output k16_isa_pkg::word_t     rd
  );
    int n;
    rd = '0;
    n = 0;
    while (!panel_ready && n < PANEL_TIMEOUT)
    begin
      step();
      n++;
    end
    if (!panel_ready)
    begin
      $display("Timeout: panel never became ready for %s", op.name());
      error_count++;
      return;
    end
    panel_cmd.op = op;
    panel_cmd.addr = addr;
    panel_cmd.data = data;
    panel_valid = 1'b1;
    step();
    panel_valid = 1'b0;
    n = 0;
    while (!panel_done && n < PANEL_TIMEOUT)
    begin
      step();
      n++;
    end
    if (!panel_done)
    begin
      $display("Timeout: panel did not finish %s at address %h", op.name(), addr);
      error_count++;
      return;
    end
    rd = examine_data;
    step();
  endtask

  task automatic deposit(input k16_isa_pkg::word_t addr, input k16_isa_pkg::word_t data);
    k16_isa_pkg::word_t unused;
    panel_command(k16_bus_pkg::PANEL_DEPOSIT, addr, data, unused);
  endtask

  task automatic examine(input k16_isa_pkg::word_t addr, output k16_isa_pkg::word_t data);
    panel_command(k16_bus_pkg::PANEL_EXAMINE, addr, '0, data);
  endtask

  task automatic start_core(input k16_isa_pkg::word_t pc);
    k16_isa_pkg::word_t unused;
    panel_command(k16_bus_pkg::PANEL_START, pc, '0, unused);
  endtask

  // Program goes to address 0, then the core runs until it halts
  task automatic run_program(input string name);
    int n;
    foreach (program_q[i])
      deposit(k16_isa_pkg::word_t'(i), program_q[i]);
    start_core(16'h0000);
    n = 0;
    while (!halted && n < RUN_TIMEOUT)
    begin
      step();
      n++;
    end
    if (!halted)
    begin
      $display("Timeout: core did not halt while running %s", name);
      error_count++;
    end
  endtask

  task automatic check_word(input string name, input k16_isa_pkg::word_t expected,
                            input k16_isa_pkg::word_t actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_halted(input string name, input bit expected, input bit actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("[FAIL] %s: expected halted %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic begin_test();
    errors_at_start = error_count;
    checks_at_start = check_count;
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("test %s finished: %0d checks, %0d errors", name,
             check_count - checks_at_start, error_count - errors_at_start);
  endtask

  task automatic verify_memory();
    k16_isa_pkg::word_t model [int];
    k16_isa_pkg::word_t rd;
    int                 addr;
    begin_test();
    check_halted("reset_halted", 1'b1, halted);
    for (int i = 0; i < 24; i++)
    begin
      addr = int'($urandom % `K16_RAM_WORDS);
      model[addr] = k16_isa_pkg::word_t'($urandom);
      deposit(k16_isa_pkg::word_t'(addr), model[addr]);
    end
    foreach (model[a])
    begin
      examine(k16_isa_pkg::word_t'(a), rd);
      check_word($sformatf("memory_%h", a), model[a], rd);
    end
    end_test("deposit_examine");
  endtask

  task automatic run_alu_programs();
    k16_isa_pkg::word_t      a;
    k16_isa_pkg::word_t      b;
    k16_isa_pkg::word_t      rd;
    k16_isa_pkg::alu_op_t    op;
    k16_isa_pkg::alu_op_t    prep;
    k16_isa_pkg::alu_class_t cls;
    alu_out_t                pre_out;
    alu_out_t                exp_out;
    begin_test();
    for (int run = 0; run < 16; run++)
    begin
      a = k16_isa_pkg::word_t'($urandom);
      b = ((run % 5) == 4) ? a : k16_isa_pkg::word_t'($urandom);
      op = k16_isa_pkg::alu_op_t'(run % 8);
      prep = (($urandom % 2) == 0) ? k16_isa_pkg::OP_ADD : k16_isa_pkg::OP_SUB;
      cls = (op < 3'd4) ? k16_isa_pkg::ALU_ARITH : k16_isa_pkg::ALU_LOGIC;
      // Preceding ADD or SUB sets the carry that ADC and SBC consume
      pre_out = k16_ref_alu(k16_isa_pkg::ALU_ARITH, prep, a, b, 1'b0);
      exp_out = k16_ref_alu(cls, op, a, b, pre_out.flags.carry);
      program_q.delete();
      program_q.push_back(load_imm(3'd0, k16_isa_pkg::IMM_LDLZ, 8'h00));
      program_q.push_back(load_word(3'd1, 3'd0, DATA_A[6:0]));
      program_q.push_back(load_word(3'd2, 3'd0, DATA_B[6:0]));
      program_q.push_back(reg_op(3'd3, 3'd1, 3'd2, {1'b0, prep}));
      program_q.push_back(reg_op(3'd4, 3'd1, 3'd2, {1'b0, op}));
      program_q.push_back(store_word(3'd4, 3'd0, DATA_OUT[6:0]));
      program_q.push_back(`K16_HALT_WORD);
      deposit(DATA_A, a);
      deposit(DATA_B, b);
      run_program("alu_run");
      examine(DATA_OUT, rd);
      check_word($sformatf("alu_op%0d_run%0d", op, run), exp_out.result, rd);
    end
    end_test("alu_runs");
  endtask

  task automatic build_immediates();
    logic [7:0]         imm [4];
    k16_isa_pkg::word_t expect_v [4];
    k16_isa_pkg::word_t rd;
    alu_out_t           ref_out;
    begin_test();
    for (int run = 0; run < 4; run++)
    begin
      foreach (imm[i])
        imm[i] = 8'($urandom);
      ref_out = k16_ref_alu(k16_isa_pkg::ALU_IMM, k16_isa_pkg::IMM_LDLZ, '0,
                            {8'h00, imm[0]}, 1'b0);
      expect_v[0] = ref_out.result;
      ref_out = k16_ref_alu(k16_isa_pkg::ALU_IMM, k16_isa_pkg::IMM_LDH, expect_v[0],
                            {8'h00, imm[1]}, 1'b0);
      expect_v[0] = ref_out.result;
      ref_out = k16_ref_alu(k16_isa_pkg::ALU_IMM, k16_isa_pkg::IMM_LDHZ, '0,
                            {8'h00, imm[2]}, 1'b0);
      expect_v[1] = ref_out.result;
      ref_out = k16_ref_alu(k16_isa_pkg::ALU_IMM, k16_isa_pkg::IMM_LDL, expect_v[1],
                            {8'h00, imm[3]}, 1'b0);
      expect_v[1] = ref_out.result;
      ref_out = k16_ref_alu(k16_isa_pkg::ALU_ARITH, k16_isa_pkg::OP_ADD, expect_v[1],
                            16'h0001, 1'b0);
      expect_v[2] = ref_out.result;
      ref_out = k16_ref_alu(k16_isa_pkg::ALU_ARITH, k16_isa_pkg::OP_SUB, expect_v[0],
                            16'h0001, 1'b0);
      expect_v[3] = ref_out.result;
      program_q.delete();
      program_q.push_back(load_imm(3'd0, k16_isa_pkg::IMM_LDLZ, 8'h00));
      program_q.push_back(load_imm(3'd1, k16_isa_pkg::IMM_LDLZ, imm[0]));
      program_q.push_back(load_imm(3'd1, k16_isa_pkg::IMM_LDH, imm[1]));
      program_q.push_back(load_imm(3'd2, k16_isa_pkg::IMM_LDHZ, imm[2]));
      program_q.push_back(load_imm(3'd2, k16_isa_pkg::IMM_LDL, imm[3]));
      // INC r3 from r2, DEC r4 from r1
      program_q.push_back(reg_op(3'd3, 3'd2, 3'd0, 4'hC));
      program_q.push_back(reg_op(3'd4, 3'd1, 3'd0, 4'hF));
      for (int i = 0; i < 4; i++)
        program_q.push_back(store_word(k16_isa_pkg::reg_idx_t'(i + 1), 3'd0,
                                       7'(DATA_OUT + i)));
      program_q.push_back(`K16_HALT_WORD);
      run_program("immediates");
      for (int i = 0; i < 4; i++)
      begin
        examine(DATA_OUT + k16_isa_pkg::word_t'(i), rd);
        check_word($sformatf("imm_run%0d_word%0d", run, i), expect_v[i], rd);
      end
    end
    end_test("immediates");
  endtask

  task automatic take_branches();
    k16_isa_pkg::word_t a;
    k16_isa_pkg::word_t b;
    k16_isa_pkg::word_t rd;
    alu_out_t           cmp_out;
    logic [2:0]         cond;
    begin_test();
    for (int run = 0; run < 16; run++)
    begin
      cond = 3'(run % 8);
      a = k16_isa_pkg::word_t'($urandom);
      b = (($urandom % 4) == 0) ? a : k16_isa_pkg::word_t'($urandom);
      cmp_out = k16_ref_alu(k16_isa_pkg::ALU_ARITH, k16_isa_pkg::OP_SUB, a, b, 1'b0);
      // Marker loaded before CMP so the flags come from CMP alone
      program_q.delete();
      program_q.push_back(load_imm(3'd0, k16_isa_pkg::IMM_LDLZ, 8'h00));
      program_q.push_back(load_imm(3'd3, k16_isa_pkg::IMM_LDLZ, MARKER[7:0]));
      program_q.push_back(load_word(3'd1, 3'd0, DATA_A[6:0]));
      program_q.push_back(load_word(3'd2, 3'd0, DATA_B[6:0]));
      program_q.push_back(reg_op(3'd0, 3'd1, 3'd2, 4'hE));
      program_q.push_back(branch_if(cond, 7'd1));
      program_q.push_back(store_word(3'd3, 3'd0, DATA_OUT[6:0]));
      program_q.push_back(`K16_HALT_WORD);
      deposit(DATA_A, a);
      deposit(DATA_B, b);
      deposit(DATA_OUT, 16'h0000);
      run_program("branches");
      examine(DATA_OUT, rd);
      check_word($sformatf("branch_cond%0d_run%0d", cond, run),
                 branch_expected(cond, cmp_out.flags) ? 16'h0000 : MARKER, rd);
    end
    end_test("branches");
  endtask

  task automatic jump_and_halt();
    k16_isa_pkg::word_t keep;
    k16_isa_pkg::word_t rd;
    begin_test();
    keep = k16_isa_pkg::word_t'($urandom);
    program_q.delete();
    program_q.push_back(load_imm(3'd0, k16_isa_pkg::IMM_LDLZ, 8'h00));
    program_q.push_back(load_imm(3'd3, k16_isa_pkg::IMM_LDLZ, MARKER[7:0]));
    program_q.push_back(jump_rel(10'd1));
    program_q.push_back(store_word(3'd3, 3'd0, DATA_OUT[6:0]));
    program_q.push_back(load_imm(3'd4, k16_isa_pkg::IMM_LDLZ, 8'h5A));
    program_q.push_back(store_word(3'd4, 3'd0, 7'(DATA_OUT + 1)));
    program_q.push_back(`K16_HALT_WORD);
    deposit(DATA_OUT, keep);
    deposit(DATA_OUT + 16'h0001, 16'h0000);
    run_program("jump_halt");
    check_halted("jump_halt", 1'b1, halted);
    examine(DATA_OUT, rd);
    check_word("jump_skipped_word", keep, rd);
    examine(DATA_OUT + 16'h0001, rd);
    check_word("jump_landing_word", 16'h005A, rd);
    end_test("jump_halt");
  endtask

  initial
  begin
    void'($urandom(32'hc995));
    reset = 1'b1;
    panel_valid = 1'b0;
    panel_cmd = '0;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    errors_at_start = 0;
    checks_at_start = 0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    verify_memory();
    run_alu_programs();
    build_immediates();
    take_branches();
    jump_and_halt();
    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- k16_system.f
+incdir+include
src/k16_isa_pkg.sv
src/k16_bus_pkg.sv
src/k16_alu.sv
src/k16_core.sv
src/k16_panel.sv
src/k16_bus_arbiter.sv
src/k16_ram.sv
src/k16_system.sv
test/k16_system_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module k16_system_tb -f k16_system.f
./obj_dir/Vk16_system_tb | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
